//--- Makefile
# Verilator flow for the vector lane

VERILATOR ?= verilator
TOP       ?= tb_vector_lane
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) verification/tb_lane_tasks.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, the exit status of the binary is not used
sim: $(BINARY)
	./$(BINARY) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+verification
verilog/lane_pkg.sv
verilog/vrf_bank.sv
verilog/mask_file.sv
verilog/operand_stage.sv
verilog/write_stage.sv
verilog/vector_lane.sv
verification/tb_vector_lane.sv

//--- verification/tb_lane_tasks.svh
`ifndef TB_LANE_TASKS_SVH
`define TB_LANE_TASKS_SVH

task automatic report_mismatch(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
   $display("Error %s: %s expected %h actual %h", test_name, what, expected, actual);
   $display("Errors found");
   $fatal(1, "Stopped at the first mismatch");
endtask

task automatic report_failure(input string msg);
   $display("Failure in %s: %s", test_name, msg);
   $display("Errors found");
   $fatal(1, "Stopped at the first failure");
endtask

task automatic clear_inputs();
   vrf_raddr_i   = '0;
   byte_sel_i    = '0;
   alu_ctrl_i    = '0;
   store_sel_i   = '0;
   store_valid_i = 1'b0;
   vrf_waddr_i   = '0;
   wr_req_i      = '0;
   alu_res_i     = '0;
   load_data_i   = '0;
   mask_addr_i   = '0;
   exp_d         = '0;
endtask

task automatic run_idle(input int cycles);
   repeat (cycles) begin
      @(posedge clk_i);
      #1;
   end
endtask

// Polls until the operand stage raises a valid
task automatic wait_for_result();
   int cycles;
   cycles = 0;
   while (alu_vld_o == '0 && !store_data_valid_o) begin
      if (cycles == TIMEOUT) begin
         report_failure("no valid from the operand stage before the timeout");
      end
      @(posedge clk_i);
      #1;
      cycles++;
   end
endtask

`endif

//--- verification/tb_vector_lane.sv
`timescale 1ns/10ps

module tb_vector_lane
   import lane_pkg::*;
   ();

   localparam int MEM_DEPTH  = 64;
   localparam int MASK_DEPTH = 32;
   localparam int AW         = $clog2(MEM_DEPTH);
   localparam int MW         = $clog2(MASK_DEPTH);
   localparam int TIMEOUT    = 20;

   // What the operand stage must show three cycles after a read
   typedef struct packed {
      logic [W_PORTS_NUM-1:0]             vld;
      logic [W_PORTS_NUM-1:0][WORD_W-1:0] vs1;
      logic [W_PORTS_NUM-1:0][WORD_W-1:0] vs2;
      alu_ctrl_t [W_PORTS_NUM-1:0]        ctrl;
      logic                               st_vld;
      logic [WORD_W-1:0]                  st_data;
   } expect_t;

   logic                                  clk_i;
   logic                                  rst_i;
   logic [R_PORTS_NUM-1:0][AW-1:0]        vrf_raddr_i;
   logic [R_PORTS_NUM-1:0][1:0]           byte_sel_i;
   alu_ctrl_t [W_PORTS_NUM-1:0]           alu_ctrl_i;
   logic [$clog2(R_PORTS_NUM)-1:0]        store_sel_i;
   logic                                  store_valid_i;
   logic [W_PORTS_NUM-1:0][AW-1:0]        vrf_waddr_i;
   wr_req_t [W_PORTS_NUM-1:0]             wr_req_i;
   logic [W_PORTS_NUM-1:0][WORD_W-1:0]    alu_res_i;
   logic [WORD_W-1:0]                     load_data_i;
   logic [W_PORTS_NUM-1:0][MW-1:0]        mask_addr_i;
   logic [W_PORTS_NUM-1:0][WORD_W-1:0]    vs1_data_o;
   logic [W_PORTS_NUM-1:0][WORD_W-1:0]    vs2_data_o;
   alu_ctrl_t [W_PORTS_NUM-1:0]           alu_ctrl_o;
   logic [W_PORTS_NUM-1:0]                alu_vld_o;
   logic [WORD_W-1:0]                     store_data_o;
   logic                                  store_data_valid_o;

   // Reference model of both memories
   logic [WORD_W-1:0]                     model_mem [MEM_DEPTH];
   logic                                  model_mask [MASK_DEPTH];
   expect_t                               exp_d;
   expect_t [VRF_DELAY-1:0]               exp_q;
   expect_t                               exp_out;
   logic                                  read_issued;
   string                                 test_name;

   initial clk_i = 1'b0;
   always #2 clk_i = ~clk_i;

   vector_lane #(
      .MEM_DEPTH  (MEM_DEPTH),
      .MASK_DEPTH (MASK_DEPTH)
   ) i_dut (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .vrf_raddr_i        (vrf_raddr_i),
      .byte_sel_i         (byte_sel_i),
      .alu_ctrl_i         (alu_ctrl_i),
      .store_sel_i        (store_sel_i),
      .store_valid_i      (store_valid_i),
      .vrf_waddr_i        (vrf_waddr_i),
      .wr_req_i           (wr_req_i),
      .alu_res_i          (alu_res_i),
      .load_data_i        (load_data_i),
      .mask_addr_i        (mask_addr_i),
      .vs1_data_o         (vs1_data_o),
      .vs2_data_o         (vs2_data_o),
      .alu_ctrl_o         (alu_ctrl_o),
      .alu_vld_o          (alu_vld_o),
      .store_data_o       (store_data_o),
      .store_data_valid_o (store_data_valid_o)
   );

   `include "tb_lane_tasks.svh"

   ////////////////////
   // Model
   ////////////////////

   // Zero extended element as the width codes define it
   function automatic logic [WORD_W-1:0] element_of(input logic [WORD_W-1:0] word,
                                                    input logic [1:0] sew,
                                                    input logic [1:0] sel);
      case (sew)
         SEW_BYTE: element_of = (word >> {sel, 3'b000}) & 32'h0000_00ff;
         SEW_HALF: element_of = (word >> {sel[0], 4'b0000}) & 32'h0000_ffff;
         SEW_WORD: element_of = word;
         default:  element_of = '0;
      endcase
   endfunction

   function automatic wr_req_t make_req(input logic src, input logic [3:0] bwen,
                                        input logic vmask, input logic commit,
                                        input logic req_ctrl, input logic mask_wen,
                                        input logic mask_bit);
      wr_req_t req;
      req.src_sel  = src;
      req.bwen     = bwen;
      req.vmask    = vmask;
      req.commit   = commit;
      req.req_ctrl = req_ctrl;
      req.mask_wen = mask_wen;
      req.mask_bit = mask_bit;
      return req;
   endfunction

   task automatic write_one(input int port, input logic [AW-1:0] addr, input wr_req_t req,
                            input logic [WORD_W-1:0] data, input logic [MW-1:0] maddr);
      logic [WORD_W/8-1:0] be;
      vrf_waddr_i[port] = addr;
      wr_req_i[port]    = req;
      mask_addr_i[port] = maddr;
      if (req.src_sel == SRC_LOAD) begin
         load_data_i = data;
      end else begin
         alu_res_i[port] = data;
      end
      // Mask is read before this request updates it
      if (req.commit || req.req_ctrl) begin
         be = req.bwen;
         if (req.vmask && !model_mask[maddr]) begin
            be = '0;
         end
         for (int b = 0; b < WORD_W/8; b++) begin
            if (be[b]) begin
               model_mem[addr][8*b +: 8] = data[8*b +: 8];
            end
         end
         if (req.mask_wen) begin
            model_mask[maddr] = req.mask_bit;
         end
      end
      @(posedge clk_i);
      #1;
      clear_inputs();
      // Commit lands VMRF_DELAY edges later
      run_idle(VMRF_DELAY);
   endtask

   task automatic read_groups(input logic [R_PORTS_NUM-1:0][AW-1:0] addr,
                              input logic [R_PORTS_NUM-1:0][1:0] bsel,
                              input logic [1:0] sew0, input logic [1:0] sew1,
                              input logic [W_PORTS_NUM-1:0] vld,
                              input logic [1:0] ssel, input logic svld);
      logic [W_PORTS_NUM-1:0][1:0] sew;
      sew = {sew1, sew0};
      for (int g = 0; g < W_PORTS_NUM; g++) begin
         alu_ctrl_i[g].opcode    = 6'($urandom());
         alu_ctrl_i[g].reduction = 1'($urandom());
         alu_ctrl_i[g].write_sew = 2'($urandom());
         alu_ctrl_i[g].read_sew  = sew[g];
         alu_ctrl_i[g].read_vld  = vld[g];
         exp_d.vld[g]  = vld[g];
         exp_d.vs1[g]  = element_of(model_mem[addr[2*g]], sew[g], bsel[2*g]);
         exp_d.vs2[g]  = element_of(model_mem[addr[2*g+1]], sew[g], bsel[2*g+1]);
         exp_d.ctrl[g] = alu_ctrl_i[g];
      end
      vrf_raddr_i   = addr;
      byte_sel_i    = bsel;
      store_sel_i   = ssel;
      store_valid_i = svld;
      exp_d.st_vld  = svld;
      exp_d.st_data = element_of(model_mem[addr[ssel]], sew[ssel[1]], bsel[ssel]);
      read_issued   = 1'b1;
      @(posedge clk_i);
      #1;
      clear_inputs();
      wait_for_result();
   endtask

   task automatic read_word(input logic [AW-1:0] addr);
      read_groups({R_PORTS_NUM{addr}}, '0, SEW_WORD, SEW_WORD, 2'b11, 2'($urandom()), 1'b1);
   endtask

   ////////////////////
   // Checks
   ////////////////////

   // Delay line mirrors the DUT latency
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         exp_q <= '0;
      end else begin
         exp_q <= {exp_q[VRF_DELAY-2:0], exp_d};
      end
   end

   assign exp_out = exp_q[VRF_DELAY-1];

   for (genvar g = 0; g < W_PORTS_NUM; g++) begin : g_group_chk
      a_alu_vld: assert property (@(posedge clk_i) disable iff (!rst_i)
         alu_vld_o[g] == exp_out.vld[g])
         else report_mismatch("alu_vld_o", 32'($sampled(exp_out.vld[g])),
                              32'($sampled(alu_vld_o[g])));
      a_vs1: assert property (@(posedge clk_i) disable iff (!rst_i)
         exp_out.vld[g] |-> vs1_data_o[g] == exp_out.vs1[g])
         else report_mismatch("vs1_data_o", $sampled(exp_out.vs1[g]), $sampled(vs1_data_o[g]));
      a_vs2: assert property (@(posedge clk_i) disable iff (!rst_i)
         exp_out.vld[g] |-> vs2_data_o[g] == exp_out.vs2[g])
         else report_mismatch("vs2_data_o", $sampled(exp_out.vs2[g]), $sampled(vs2_data_o[g]));
      a_ctrl: assert property (@(posedge clk_i) disable iff (!rst_i)
         exp_out.vld[g] |-> alu_ctrl_o[g] == exp_out.ctrl[g])
         else report_mismatch("alu_ctrl_o", 32'($sampled(exp_out.ctrl[g])),
                              32'($sampled(alu_ctrl_o[g])));
   end

   a_store_vld: assert property (@(posedge clk_i) disable iff (!rst_i)
      store_data_valid_o == exp_out.st_vld)
      else report_mismatch("store_data_valid_o", 32'($sampled(exp_out.st_vld)),
                           32'($sampled(store_data_valid_o)));
   a_store_data: assert property (@(posedge clk_i) disable iff (!rst_i)
      exp_out.st_vld |-> store_data_o == exp_out.st_data)
      else report_mismatch("store_data_o", $sampled(exp_out.st_data), $sampled(store_data_o));
   a_idle_zero: assert property (@(posedge clk_i) disable iff (!rst_i)
      !read_issued |-> (alu_vld_o == '0 && !store_data_valid_o && vs1_data_o == '0
                        && vs2_data_o == '0 && store_data_o == '0))
      else report_failure("operand or store outputs not zero before the first read");

   ////////////////////
   // Stimulus
   ////////////////////
   initial begin
      logic [R_PORTS_NUM-1:0][AW-1:0] ra;
      logic [R_PORTS_NUM-1:0][1:0]    bs;
      void'($urandom(32'h4eeb161d));
      clear_inputs();
      read_issued = 1'b0;
      test_name   = "reset";
      rst_i       = 1'b0;
      repeat (3) @(posedge clk_i);
      #1;
      rst_i = 1'b1;
      run_idle(4);

      // Every word gets a known value first
      test_name = "fill";
      for (int a = 0; a < MEM_DEPTH; a++) begin
         write_one(a % W_PORTS_NUM, AW'(a), make_req(SRC_ALU, 4'hf, 0, 1, 0, 0, 0),
                   $urandom(), '0);
      end

      test_name = "word_read";
      write_one(0, AW'(5), make_req(SRC_ALU, 4'hf, 0, 1, 0, 0, 0), 32'ha5c3_1e07, '0);
      read_word(AW'(5));

      test_name = "elem_read";
      write_one(1, AW'(9), make_req(SRC_ALU, 4'hf, 0, 1, 0, 0, 0), 32'h8f70_c2e4, '0);
      for (int s = 0; s < 2; s++) begin
         for (int b = 0; b < 4; b++) begin
            ra = {AW'(9), AW'(5), AW'(9), AW'(5)};
            bs = {R_PORTS_NUM{2'(b)}};
            read_groups(ra, bs, 2'(s), 2'(s), 2'b11, 2'(b), 1'b1);
         end
      end

      test_name = "partial_bwen";
      write_one(0, AW'(7), make_req(SRC_ALU, 4'b0101, 0, 1, 0, 0, 0), 32'h1122_3344, '0);
      read_word(AW'(7));
      write_one(1, AW'(7), make_req(SRC_ALU, 4'b1010, 0, 0, 1, 0, 0), 32'h5566_7788, '0);
      read_word(AW'(7));
      write_one(0, AW'(7), make_req(SRC_ALU, 4'hf, 0, 0, 0, 0, 0), 32'hdead_beef, '0);
      read_word(AW'(7));

      test_name = "mask";
      write_one(0, AW'(11), make_req(SRC_ALU, 4'h0, 0, 1, 0, 1, 0), '0, MW'(3));
      write_one(1, AW'(11), make_req(SRC_ALU, 4'hf, 1, 1, 0, 0, 0), 32'hcafe_f00d, MW'(3));
      read_word(AW'(11));
      write_one(0, AW'(11), make_req(SRC_ALU, 4'hf, 0, 1, 0, 0, 0), 32'h0bad_1dea, MW'(3));
      read_word(AW'(11));
      write_one(1, AW'(11), make_req(SRC_ALU, 4'h0, 0, 1, 0, 1, 1), '0, MW'(3));
      write_one(0, AW'(11), make_req(SRC_ALU, 4'hf, 1, 1, 0, 0, 0), 32'h600d_cafe, MW'(3));
      read_word(AW'(11));

      test_name = "random";
      for (int i = 0; i < 48; i++) begin
         write_one(int'($urandom() % 2), AW'($urandom()),
                   make_req(SRC_LOAD, 4'($urandom()), 0, 1, 0, 0, 0), $urandom(), '0);
         for (int p = 0; p < R_PORTS_NUM; p++) begin
            ra[p] = AW'($urandom());
            bs[p] = 2'($urandom());
         end
         read_groups(ra, bs, 2'($urandom() % 3), 2'($urandom() % 3), 2'($urandom()),
                     2'($urandom()), 1'b1);
      end

      run_idle(4);
      $display("No errors");
      $finish;
   end

endmodule

//--- verilog/lane_pkg.sv
package lane_pkg;

   ////////////////////
   // Lane geometry
   ////////////////////
   localparam int WORD_W      = 32;
   localparam int R_PORTS_NUM = 4;
   localparam int W_PORTS_NUM = 2;

   // Request to operand latency
   localparam int VRF_DELAY   = 3;
   // Write request to commit latency, equal to the memory read latency
   localparam int VMRF_DELAY  = 2;

   // Element width codes
   localparam logic [1:0] SEW_BYTE = 2'd0;
   localparam logic [1:0] SEW_HALF = 2'd1;
   localparam logic [1:0] SEW_WORD = 2'd2;

   // Write data source codes
   localparam logic SRC_ALU  = 1'b0;
   localparam logic SRC_LOAD = 1'b1;

   ////////////////////
   // Types
   ////////////////////

   // One VRF word seen as bytes or as halfwords
   typedef union packed {
      logic [WORD_W/8-1:0][7:0]  bytes;
      logic [WORD_W/16-1:0][15:0] halves;
   } lane_word_u;

   // ALU control of one lane group
   typedef struct packed {
      logic [5:0] opcode;
      logic       reduction;
      logic [1:0] read_sew;
      logic [1:0] write_sew;
      logic       read_vld;
   } alu_ctrl_t;

   // Write request of one write port
   typedef struct packed {
      logic                  src_sel;
      logic [WORD_W/8-1:0]   bwen;
      logic                  vmask;
      logic                  commit;
      logic                  req_ctrl;
      logic                  mask_wen;
      logic                  mask_bit;
   } wr_req_t;

endpackage

//--- verilog/mask_file.sv
`timescale 1ns/10ps

module mask_file
   import lane_pkg::*;
   #(
   parameter int MASK_DEPTH = 32
   )
   (
   input  logic                                           clk_i,
   input  logic                                           rst_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(MASK_DEPTH)-1:0] raddr_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(MASK_DEPTH)-1:0] waddr_i,
   input  logic [W_PORTS_NUM-1:0]                         wbit_i,
   input  logic [W_PORTS_NUM-1:0]                         wen_i,
   output logic [W_PORTS_NUM-1:0]                         rbit_o
   );

   localparam int MW = $clog2(MASK_DEPTH);

   logic                           mask_mem [MASK_DEPTH];
   logic [W_PORTS_NUM-1:0][MW-1:0] raddr_q;
   logic [W_PORTS_NUM-1:0]         rbit_q;

   // Shared array, higher port wins on a clash
   always_ff @(posedge clk_i) begin
      for (int w = 0; w < W_PORTS_NUM; w++) begin
         if (wen_i[w]) begin
            mask_mem[waddr_i[w]] <= wbit_i[w];
         end
      end
   end

   // Two register stages so the bit lines up with the commit stage
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         raddr_q <= '0;
      end else begin
         raddr_q <= raddr_i;
      end
   end

   always_ff @(posedge clk_i) begin
      for (int p = 0; p < W_PORTS_NUM; p++) begin
         rbit_q[p] <= mask_mem[raddr_q[p]];
      end
   end

   assign rbit_o = rbit_q;

endmodule

//--- verilog/operand_stage.sv
`timescale 1ns/10ps

module operand_stage
   import lane_pkg::*;
   (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  logic [R_PORTS_NUM-1:0][WORD_W-1:0] rdata_i,
   input  logic [R_PORTS_NUM-1:0][1:0]        byte_sel_i,
   input  alu_ctrl_t [W_PORTS_NUM-1:0]        alu_ctrl_i,
   input  logic [$clog2(R_PORTS_NUM)-1:0]     store_sel_i,
   input  logic                               store_valid_i,
   output logic [W_PORTS_NUM-1:0][WORD_W-1:0] vs1_data_o,
   output logic [W_PORTS_NUM-1:0][WORD_W-1:0] vs2_data_o,
   output alu_ctrl_t [W_PORTS_NUM-1:0]        alu_ctrl_o,
   output logic [W_PORTS_NUM-1:0]             alu_vld_o,
   output logic [WORD_W-1:0]                  store_data_o,
   output logic                               store_data_valid_o
   );

   localparam int SW = $clog2(R_PORTS_NUM);

   typedef struct packed {
      logic [SW-1:0] sel;
      logic          vld;
   } store_ctrl_t;

   ////////////////////
   // Control pipeline
   ////////////////////
   alu_ctrl_t [VRF_DELAY-1:0][W_PORTS_NUM-1:0]   ctrl_q;
   store_ctrl_t [VRF_DELAY-1:0]                  st_q;
   // Byte selects only need to reach the raw data stage
   logic [VRF_DELAY-2:0][R_PORTS_NUM-1:0][1:0]   bsel_q;

   lane_word_u [R_PORTS_NUM-1:0]                 raw;
   logic [R_PORTS_NUM-1:0][WORD_W-1:0]           elem_d;
   logic [R_PORTS_NUM-1:0][WORD_W-1:0]           elem_q;
   logic [R_PORTS_NUM-1:0]                       elem_ld;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ctrl_q <= '0;
         st_q   <= '0;
         bsel_q <= '0;
      end else begin
         ctrl_q <= {ctrl_q[VRF_DELAY-2:0], alu_ctrl_i};
         st_q   <= {st_q[VRF_DELAY-2:0], store_ctrl_t'({store_sel_i, store_valid_i})};
         bsel_q <= {bsel_q[VRF_DELAY-3:0], byte_sel_i};
      end
   end

   ////////////////////
   // Element extraction
   ////////////////////
   assign raw = rdata_i;

   // Width comes from the group that owns the port
   always_comb begin
      for (int p = 0; p < R_PORTS_NUM; p++) begin
         case (ctrl_q[VRF_DELAY-2][p/2].read_sew)
            SEW_BYTE: elem_d[p] = WORD_W'(raw[p].bytes[bsel_q[VRF_DELAY-2][p]]);
            SEW_HALF: elem_d[p] = WORD_W'(raw[p].halves[bsel_q[VRF_DELAY-2][p][0]]);
            SEW_WORD: elem_d[p] = raw[p];
            default:  elem_d[p] = '0;
         endcase
         // Load only for reads that someone asked for
         elem_ld[p] = ctrl_q[VRF_DELAY-2][p/2].read_vld
                    | (st_q[VRF_DELAY-2].vld && st_q[VRF_DELAY-2].sel == SW'(p));
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         elem_q <= '0;
      end else begin
         for (int p = 0; p < R_PORTS_NUM; p++) begin
            if (elem_ld[p]) begin
               elem_q[p] <= elem_d[p];
            end
         end
      end
   end

   ////////////////////
   // Operand routing
   ////////////////////
   always_comb begin
      for (int g = 0; g < W_PORTS_NUM; g++) begin
         vs1_data_o[g] = elem_q[2*g];
         vs2_data_o[g] = elem_q[2*g+1];
         alu_vld_o[g]  = ctrl_q[VRF_DELAY-1][g].read_vld;
      end
   end

   assign alu_ctrl_o = ctrl_q[VRF_DELAY-1];

   // Store data taken from the registered elements
   assign store_data_o       = elem_q[st_q[VRF_DELAY-1].sel];
   assign store_data_valid_o = st_q[VRF_DELAY-1].vld;

endmodule

//--- verilog/vector_lane.sv
`timescale 1ns/10ps

module vector_lane
   import lane_pkg::*;
   #(
   parameter int MEM_DEPTH  = 64,
   parameter int MASK_DEPTH = 32
   )
   (
   input  logic                                           clk_i,
   input  logic                                           rst_i,
   // Read request
   input  logic [R_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0]  vrf_raddr_i,
   input  logic [R_PORTS_NUM-1:0][1:0]                    byte_sel_i,
   input  alu_ctrl_t [W_PORTS_NUM-1:0]                    alu_ctrl_i,
   input  logic [$clog2(R_PORTS_NUM)-1:0]                 store_sel_i,
   input  logic                                           store_valid_i,
   // Write request
   input  logic [W_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0]  vrf_waddr_i,
   input  wr_req_t [W_PORTS_NUM-1:0]                      wr_req_i,
   input  logic [W_PORTS_NUM-1:0][WORD_W-1:0]             alu_res_i,
   input  logic [WORD_W-1:0]                              load_data_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(MASK_DEPTH)-1:0] mask_addr_i,
   // Operands towards the ALUs
   output logic [W_PORTS_NUM-1:0][WORD_W-1:0]             vs1_data_o,
   output logic [W_PORTS_NUM-1:0][WORD_W-1:0]             vs2_data_o,
   output alu_ctrl_t [W_PORTS_NUM-1:0]                    alu_ctrl_o,
   output logic [W_PORTS_NUM-1:0]                         alu_vld_o,
   // Store data
   output logic [WORD_W-1:0]                              store_data_o,
   output logic                                           store_data_valid_o
   );

   localparam int AW = $clog2(MEM_DEPTH);
   localparam int MW = $clog2(MASK_DEPTH);

   ////////////////////
   // Internal wires
   ////////////////////
   logic [R_PORTS_NUM-1:0][WORD_W-1:0]   vrf_rdata;
   logic [W_PORTS_NUM-1:0][AW-1:0]       vrf_waddr;
   logic [W_PORTS_NUM-1:0][WORD_W-1:0]   vrf_wdata;
   logic [W_PORTS_NUM-1:0][WORD_W/8-1:0] vrf_bwen;
   logic [W_PORTS_NUM-1:0]               mask_rbit;
   logic [W_PORTS_NUM-1:0][MW-1:0]       mask_waddr;
   logic [W_PORTS_NUM-1:0]               mask_wbit;
   logic [W_PORTS_NUM-1:0]               mask_wen;

   vrf_bank #(
      .MEM_DEPTH (MEM_DEPTH)
   ) i_vrf_bank (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .raddr_i (vrf_raddr_i),
      .waddr_i (vrf_waddr),
      .wdata_i (vrf_wdata),
      .bwen_i  (vrf_bwen),
      .rdata_o (vrf_rdata)
   );

   // Mask read address goes straight in, the write address comes back delayed
   mask_file #(
      .MASK_DEPTH (MASK_DEPTH)
   ) i_mask_file (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .raddr_i (mask_addr_i),
      .waddr_i (mask_waddr),
      .wbit_i  (mask_wbit),
      .wen_i   (mask_wen),
      .rbit_o  (mask_rbit)
   );

   operand_stage i_operand_stage (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .rdata_i            (vrf_rdata),
      .byte_sel_i         (byte_sel_i),
      .alu_ctrl_i         (alu_ctrl_i),
      .store_sel_i        (store_sel_i),
      .store_valid_i      (store_valid_i),
      .vs1_data_o         (vs1_data_o),
      .vs2_data_o         (vs2_data_o),
      .alu_ctrl_o         (alu_ctrl_o),
      .alu_vld_o          (alu_vld_o),
      .store_data_o       (store_data_o),
      .store_data_valid_o (store_data_valid_o)
   );

   write_stage #(
      .MEM_DEPTH  (MEM_DEPTH),
      .MASK_DEPTH (MASK_DEPTH)
   ) i_write_stage (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .waddr_i      (vrf_waddr_i),
      .wr_req_i     (wr_req_i),
      .alu_res_i    (alu_res_i),
      .load_data_i  (load_data_i),
      .mask_addr_i  (mask_addr_i),
      .mask_bit_i   (mask_rbit),
      .vrf_waddr_o  (vrf_waddr),
      .vrf_wdata_o  (vrf_wdata),
      .vrf_bwen_o   (vrf_bwen),
      .mask_waddr_o (mask_waddr),
      .mask_wbit_o  (mask_wbit),
      .mask_wen_o   (mask_wen)
   );

endmodule

//--- verilog/vrf_bank.sv
`timescale 1ns/10ps

module vrf_bank
   import lane_pkg::*;
   #(
   parameter int MEM_DEPTH = 64
   )
   (
   input  logic                                          clk_i,
   input  logic                                          rst_i,
   input  logic [R_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0] raddr_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0] waddr_i,
   input  logic [W_PORTS_NUM-1:0][WORD_W-1:0]            wdata_i,
   input  logic [W_PORTS_NUM-1:0][WORD_W/8-1:0]          bwen_i,
   output logic [R_PORTS_NUM-1:0][WORD_W-1:0]            rdata_o
   );

   localparam int AW = $clog2(MEM_DEPTH);
   localparam int NB = WORD_W / 8;

   // Register array, one byte lane per write enable bit
   logic [NB-1:0][7:0]                 mem [MEM_DEPTH];
   logic [R_PORTS_NUM-1:0][AW-1:0]     raddr_q;
   logic [R_PORTS_NUM-1:0][WORD_W-1:0] rdata_q;

   ////////////////////
   // Write ports
   ////////////////////

   // Later ports overwrite earlier ones on the same byte
   always_ff @(posedge clk_i) begin
      for (int w = 0; w < W_PORTS_NUM; w++) begin
         for (int b = 0; b < NB; b++) begin
            if (bwen_i[w][b]) begin
               mem[waddr_i[w]][b] <= wdata_i[w][b*8 +: 8];
            end
         end
      end
   end

   ////////////////////
   // Read ports
   ////////////////////

   // First cycle latches the address
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         raddr_q <= '0;
      end else begin
         raddr_q <= raddr_i;
      end
   end

   // Second cycle latches the word
   always_ff @(posedge clk_i) begin
      for (int p = 0; p < R_PORTS_NUM; p++) begin
         rdata_q[p] <= mem[raddr_q[p]];
      end
   end

   assign rdata_o = rdata_q;

endmodule

//--- verilog/write_stage.sv
`timescale 1ns/10ps

module write_stage
   import lane_pkg::*;
   #(
   parameter int MEM_DEPTH  = 64,
   parameter int MASK_DEPTH = 32
   )
   (
   input  logic                                           clk_i,
   input  logic                                           rst_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0]  waddr_i,
   input  wr_req_t [W_PORTS_NUM-1:0]                      wr_req_i,
   input  logic [W_PORTS_NUM-1:0][WORD_W-1:0]             alu_res_i,
   input  logic [WORD_W-1:0]                              load_data_i,
   input  logic [W_PORTS_NUM-1:0][$clog2(MASK_DEPTH)-1:0] mask_addr_i,
   input  logic [W_PORTS_NUM-1:0]                         mask_bit_i,
   output logic [W_PORTS_NUM-1:0][$clog2(MEM_DEPTH)-1:0]  vrf_waddr_o,
   output logic [W_PORTS_NUM-1:0][WORD_W-1:0]             vrf_wdata_o,
   output logic [W_PORTS_NUM-1:0][WORD_W/8-1:0]           vrf_bwen_o,
   output logic [W_PORTS_NUM-1:0][$clog2(MASK_DEPTH)-1:0] mask_waddr_o,
   output logic [W_PORTS_NUM-1:0]                         mask_wbit_o,
   output logic [W_PORTS_NUM-1:0]                         mask_wen_o
   );

   localparam int AW = $clog2(MEM_DEPTH);
   localparam int MW = $clog2(MASK_DEPTH);

   typedef struct packed {
      logic [AW-1:0]     waddr;
      logic [WORD_W-1:0] wdata;
      logic [MW-1:0]     maddr;
   } wr_payload_t;

   wr_payload_t [W_PORTS_NUM-1:0]                  pay_d;
   wr_payload_t [VMRF_DELAY-1:0][W_PORTS_NUM-1:0]  pay_q;
   wr_req_t [VMRF_DELAY-1:0][W_PORTS_NUM-1:0]      req_q;
   logic [W_PORTS_NUM-1:0]                         commit_en;
   logic [W_PORTS_NUM-1:0][WORD_W/8-1:0]           masked_bwen;

   ////////////////////
   // Data select
   ////////////////////
   always_comb begin
      for (int p = 0; p < W_PORTS_NUM; p++) begin
         pay_d[p].waddr = waddr_i[p];
         pay_d[p].maddr = mask_addr_i[p];
         pay_d[p].wdata = (wr_req_i[p].src_sel == SRC_LOAD) ? load_data_i : alu_res_i[p];
      end
   end

   ////////////////////
   // Delay line
   ////////////////////
   always_ff @(posedge clk_i) begin
      pay_q <= {pay_q[VMRF_DELAY-2:0], pay_d};
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         req_q <= '0;
      end else begin
         req_q <= {req_q[VMRF_DELAY-2:0], wr_req_i};
      end
   end

   ////////////////////
   // Commit stage
   ////////////////////

   // Mask bit read for this request arrives together with it
   always_comb begin
      for (int p = 0; p < W_PORTS_NUM; p++) begin
         commit_en[p]   = req_q[VMRF_DELAY-1][p].commit | req_q[VMRF_DELAY-1][p].req_ctrl;
         masked_bwen[p] = req_q[VMRF_DELAY-1][p].bwen;
         if (req_q[VMRF_DELAY-1][p].vmask) begin
            masked_bwen[p] = masked_bwen[p] & {(WORD_W/8){mask_bit_i[p]}};
         end
         vrf_bwen_o[p]   = commit_en[p] ? masked_bwen[p] : '0;
         mask_wen_o[p]   = req_q[VMRF_DELAY-1][p].mask_wen & commit_en[p];
         mask_wbit_o[p]  = req_q[VMRF_DELAY-1][p].mask_bit;
         vrf_waddr_o[p]  = pay_q[VMRF_DELAY-1][p].waddr;
         vrf_wdata_o[p]  = pay_q[VMRF_DELAY-1][p].wdata;
         mask_waddr_o[p] = pay_q[VMRF_DELAY-1][p].maddr;
      end
   end

endmodule
